//--- files.f
memSysPkg.sv
instrCache.sv
dataCache.sv
busArbiter.sv
ahbMemory.sv
memSystem.sv
tbMemSystem.sv

//--- Bender.yml
package:
  name: memSystem

sources:
  - memSysPkg.sv
  - instrCache.sv
  - dataCache.sv
  - busArbiter.sv
  - ahbMemory.sv
  - memSystem.sv
  - target: test
    files:
      - tbMemSystem.sv

//--- tbMemSystem.sv
// Memory subsystem testbench with core stimulus, reference model, compare process and report
module tbMemSystem;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int numWrites = 32;
  localparam int numRandom = 200;
  // About 600 accesses of up to 15 cycles each, doubled for bus contention
  localparam int timeoutCycles = 20000;

  logic        clk;
  logic        rstN;
  logic [31:0] pcF;
  logic [31:0] instrF;
  logic        iStall;
  logic [31:0] dataAdrM;
  logic [31:0] writeDataM;
  logic        memWriteM;
  logic        memtoRegM;
  logic [3:0]  byteMaskM;
  logic [31:0] readDataM;
  logic        dStall;
  logic        iCacheEn;
  logic        dCacheEn;
  logic        invI;
  logic        invD;

  // Reference memory and the instruction lines as they were filled
  logic [31:0]                   refMem [memSysPkg::memWords];
  logic [31:0]                   snapWord [memSysPkg::numILines][memSysPkg::blockWords];
  logic [memSysPkg::iTagBits-1:0] snapTag [memSysPkg::numILines];
  logic                          snapValid [memSysPkg::numILines];

  logic [3:0]  maskTable [7] = '{4'b1111, 4'b0011, 4'b1100, 4'b0001, 4'b0010, 4'b0100, 4'b1000};
  logic [31:0] rngState = 32'h980c_80e6;
  logic [31:0] expVal;
  bit          dPending;
  bit          iPending;
  logic        iStallPrev;
  string       testName;
  int          passCount;
  int          failCount;
  int          testFailStart;
  int          cycleCount;

  memSystem i_memSystem (
    .clk       (clk       ),
    .rstN      (rstN      ),
    .pcF       (pcF       ),
    .instrF    (instrF    ),
    .iStall    (iStall    ),
    .dataAdrM  (dataAdrM  ),
    .writeDataM(writeDataM),
    .memWriteM (memWriteM ),
    .memtoRegM (memtoRegM ),
    .byteMaskM (byteMaskM ),
    .readDataM (readDataM ),
    .dStall    (dStall    ),
    .iCacheEn  (iCacheEn  ),
    .dCacheEn  (dCacheEn  ),
    .invI      (invI      ),
    .invD      (invD      )
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRand();
    rngState = xorshift(rngState);
    return rngState;
  endfunction

  function automatic int wordIdx(input logic [31:0] adr);
    return adr[memSysPkg::memAdrBits+1:2];
  endfunction

  function automatic int lineIdx(input logic [31:0] pc);
    return pc[memSysPkg::offsetBits+2 +: memSysPkg::iIndexBits];
  endfunction

  function automatic logic [31:0] mergeBytes(input logic [31:0] oldWord, input logic [31:0] data,
                                              input logic [3:0] mask);
    logic [31:0] res;
    res = oldWord;
    for (int b = 0; b < 4; b++)
      if (mask[b])
        res[8*b +: 8] = data[8*b +: 8];
    return res;
  endfunction

  // Data reads always see memory since the data cache is write-through
  function automatic logic [31:0] expectedRead(input logic [31:0] adr);
    return refMem[wordIdx(adr)];
  endfunction

  // Fetches see the line as it was when filled
  function automatic logic [31:0] expectedFetch(input logic [31:0] pc);
    return snapWord[lineIdx(pc)][pc[3:2]];
  endfunction

  task automatic takeSnapshot(input logic [31:0] pc);
    for (int w = 0; w < memSysPkg::blockWords; w++)
      snapWord[lineIdx(pc)][w] = refMem[wordIdx((pc & ~32'hf) + 4 * w)];
    snapTag[lineIdx(pc)]   = pc[31 -: memSysPkg::iTagBits];
    snapValid[lineIdx(pc)] = 1'b1;
  endtask

  // Every access is checked in the cycle its stall is low
  always @(negedge clk)
  begin
    if (dPending && !dStall)
    begin
      if (memWriteM)
        refMem[wordIdx(dataAdrM)] = mergeBytes(refMem[wordIdx(dataAdrM)], writeDataM, byteMaskM);
      else
      begin
        expVal = expectedRead(dataAdrM);
        if (readDataM !== expVal)
        begin
          $display("MISMATCH %s: read at %h expected %h actual %h", testName, dataAdrM, expVal,
                   readDataM);
          failCount++;
        end
        else
          passCount++;
      end
      dPending = 1'b0;
    end
    // Falling iStall marks the end of every line fill including background refills
    if (iCacheEn && iStallPrev && !iStall)
      takeSnapshot(pcF);
    if (iPending && !iStall)
    begin
      expVal = expectedFetch(pcF);
      if (!snapValid[lineIdx(pcF)] || snapTag[lineIdx(pcF)] !== pcF[31 -: memSysPkg::iTagBits])
      begin
        $display("ERROR %s: fetch at %h hit a line that was never filled", testName, pcF);
        failCount++;
      end
      else if (instrF !== expVal)
      begin
        $display("MISMATCH %s: fetch at %h expected %h actual %h", testName, pcF, expVal,
                 instrF);
        failCount++;
      end
      else
        passCount++;
      iPending = 1'b0;
    end
    iStallPrev = iStall;
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= timeoutCycles)
    begin
      $display("ERROR: run hung, no end after %0d cycles", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  // Starts 1 ns after a rising edge and returns 1 ns after the edge that ends the access
  task automatic dataAccess(input logic wr, input logic [31:0] adr, input logic [31:0] data,
                            input logic [3:0] mask, output logic stalled);
    dataAdrM   = adr;
    writeDataM = data;
    byteMaskM  = mask;
    memWriteM  = wr;
    memtoRegM  = !wr;
    dPending   = 1'b1;
    @(negedge clk);
    stalled = dStall;
    wait (!dPending);
    @(posedge clk);
    #1;
    memWriteM = 1'b0;
    memtoRegM = 1'b0;
  endtask

  task automatic fetch(input logic [31:0] pc);
    logic waited;
    logic expHit;
    logic stalled;
    waited = 1'b0;
    // pcF only moves once the fetch side has settled
    while (iStall)
    begin
      @(posedge clk);
      #1;
      waited = 1'b1;
    end
    // A finished background refill is recorded under its own pcF first
    if (waited)
    begin
      @(posedge clk);
      #1;
    end
    expHit   = snapValid[lineIdx(pc)] &&
               (snapTag[lineIdx(pc)] === pc[31 -: memSysPkg::iTagBits]);
    pcF      = pc;
    iPending = 1'b1;
    @(negedge clk);
    stalled = iStall;
    wait (!iPending);
    @(posedge clk);
    #1;
    checkStall(stalled, !expHit, pc);
  endtask

  task automatic pulseInvD();
    invD = 1'b1;
    @(posedge clk);
    #1;
    invD = 1'b0;
  endtask

  task automatic pulseInvI();
    invI = 1'b1;
    @(posedge clk);
    for (int i = 0; i < memSysPkg::numILines; i++)
      snapValid[i] = 1'b0;
    #1;
    invI = 1'b0;
  endtask

  task automatic checkStall(input logic stalled, input logic expected, input logic [31:0] adr);
    if (stalled !== expected)
    begin
      $display("ERROR %s: access at %h %s", testName, adr,
               expected ? "did not stall on a miss" : "stalled on a hit");
      failCount++;
    end
    else
      passCount++;
  endtask

  task automatic startTest(input string name);
    testName      = name;
    testFailStart = failCount;
  endtask

  task automatic finishTest();
    $display("Test %s finished with %0d errors", testName, failCount - testFailStart);
  endtask

  task automatic randomData(input int count);
    logic [31:0] r;
    logic [31:0] adr;
    logic        stalled;
    for (int n = 0; n < count; n++)
    begin
      r   = nextRand();
      adr = 32'h200 + ((r >> 8) % 128) * 4;
      if (r[3:0] == 4'd0)
        pulseInvD();
      if (r[4])
        dataAccess(1'b1, adr, nextRand(), maskTable[r[7:5] % 7], stalled);
      else
        dataAccess(1'b0, adr, '0, 4'hf, stalled);
    end
  endtask

  task automatic randomFetch(input int count);
    logic [31:0] r;
    for (int n = 0; n < count; n++)
    begin
      r = nextRand();
      if (r[3:0] == 4'd0)
        pulseInvI();
      fetch(32'h200 + ((r >> 8) % 128) * 4);
    end
  endtask

  initial
  begin
    logic        stalled;
    logic [31:0] adr;
    logic [31:0] written [$];
    clk        = 1'b0;
    rstN       = 1'b0;
    pcF        = '0;
    dataAdrM   = '0;
    writeDataM = '0;
    memWriteM  = 1'b0;
    memtoRegM  = 1'b0;
    byteMaskM  = 4'hf;
    iCacheEn   = 1'b0;
    dCacheEn   = 1'b0;
    invI       = 1'b0;
    invD       = 1'b0;
    iStallPrev = 1'b1;
    for (int i = 0; i < memSysPkg::memWords; i++)
      refMem[i] = '0;
    for (int i = 0; i < memSysPkg::numILines; i++)
      snapValid[i] = 1'b0;
    repeat (4) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Both caches off with writes of every width then reads
    startTest("uncachedData");
    for (int n = 0; n < numWrites; n++)
    begin
      adr = (nextRand() % 64) * 4;
      written.push_back(adr);
      dataAccess(1'b1, adr, nextRand(), maskTable[nextRand() % 7], stalled);
    end
    foreach (written[k])
      dataAccess(1'b0, written[k], '0, 4'hf, stalled);
    finishTest();

    startTest("dataCacheHits");
    dCacheEn = 1'b1;
    dataAccess(1'b0, 32'h40, '0, 4'hf, stalled);
    checkStall(stalled, 1'b1, 32'h40);
    for (int w = 1; w <= 4; w++)
    begin
      adr = 32'h40 + (w % 4) * 4;
      dataAccess(1'b0, adr, '0, 4'hf, stalled);
      checkStall(stalled, 1'b0, adr);
    end
    dataAccess(1'b1, 32'h48, nextRand(), 4'b1100, stalled);
    dataAccess(1'b0, 32'h48, '0, 4'hf, stalled);
    checkStall(stalled, 1'b0, 32'h48);
    pulseInvD();
    dCacheEn = 1'b0;
    dataAccess(1'b0, 32'h48, '0, 4'hf, stalled);
    dCacheEn = 1'b1;
    finishTest();

    // Lines stay stale after a data write until invI
    startTest("instrCacheStale");
    for (int w = 0; w < 8; w++)
      dataAccess(1'b1, 32'h200 + w * 4, nextRand(), 4'hf, stalled);
    iCacheEn = 1'b1;
    @(posedge clk);
    #1;
    for (int w = 0; w < 8; w++)
      fetch(32'h200 + w * 4);
    dataAccess(1'b1, 32'h204, ~expectedRead(32'h204), 4'hf, stalled);
    fetch(32'h204);
    pulseInvI();
    fetch(32'h204);
    finishTest();

    startTest("dataInvalidate");
    dataAccess(1'b0, 32'h300, '0, 4'hf, stalled);
    dataAccess(1'b0, 32'h304, '0, 4'hf, stalled);
    checkStall(stalled, 1'b0, 32'h304);
    pulseInvD();
    dataAccess(1'b0, 32'h300, '0, 4'hf, stalled);
    checkStall(stalled, 1'b1, 32'h300);
    finishTest();

    startTest("concurrentRandom");
    fork
      randomData(numRandom);
      randomFetch(numRandom);
    join
    finishTest();

    $display("Checks passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- memSystem.sv
// Top level joining instruction cache, data cache, bus arbiter and word memory
module memSystem (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [memSysPkg::dataWidth-1:0]   pcF,
  output logic [memSysPkg::dataWidth-1:0]   instrF,
  output logic                              iStall,
  input  logic [memSysPkg::dataWidth-1:0]   dataAdrM,
  input  logic [memSysPkg::dataWidth-1:0]   writeDataM,
  input  logic                              memWriteM,
  input  logic                              memtoRegM,
  input  logic [memSysPkg::dataWidth/8-1:0] byteMaskM,
  output logic [memSysPkg::dataWidth-1:0]   readDataM,
  output logic                              dStall,
  input  logic                              iCacheEn,
  input  logic                              dCacheEn,
  input  logic                              invI,
  input  logic                              invD
);

  // Fetch master
  logic                            hRequestF;
  logic                            hReadyF;
  logic [memSysPkg::dataWidth-1:0] hAddrF;

  // Data master
  logic                            hRequestM;
  logic                            hReadyM;
  logic                            hWriteM;
  logic [memSysPkg::hSizeBits-1:0] hSizeM;
  logic [memSysPkg::dataWidth-1:0] hAddrM;
  logic [memSysPkg::dataWidth-1:0] hWDataM;

  // Shared bus to the memory
  logic                            hRequest;
  logic                            hReady;
  logic                            hWrite;
  logic [memSysPkg::hSizeBits-1:0] hSize;
  logic [memSysPkg::dataWidth-1:0] hAddr;
  logic [memSysPkg::dataWidth-1:0] hWData;
  logic [memSysPkg::dataWidth-1:0] hRData;

  instrCache i_instrCache (
    .clk       (clk      ),
    .rstN      (rstN     ),
    .enable    (iCacheEn ),
    .invalidate(invI     ),
    .pcF       (pcF      ),
    .hReadyF   (hReadyF  ),
    .hRData    (hRData   ),
    .instrF    (instrF   ),
    .iStall    (iStall   ),
    .hRequestF (hRequestF),
    .hAddrF    (hAddrF   )
  );

  dataCache i_dataCache (
    .clk       (clk       ),
    .rstN      (rstN      ),
    .enable    (dCacheEn  ),
    .invalidate(invD      ),
    .dataAdrM  (dataAdrM  ),
    .writeDataM(writeDataM),
    .memWriteM (memWriteM ),
    .memtoRegM (memtoRegM ),
    .byteMaskM (byteMaskM ),
    .hReadyM   (hReadyM   ),
    .hRData    (hRData    ),
    .readDataM (readDataM ),
    .dStall    (dStall    ),
    .hRequestM (hRequestM ),
    .hAddrM    (hAddrM    ),
    .hWriteM   (hWriteM   ),
    .hSizeM    (hSizeM    ),
    .hWDataM   (hWDataM   )
  );

  busArbiter i_busArbiter (
    .clk      (clk      ),
    .rstN     (rstN     ),
    .hRequestF(hRequestF),
    .hAddrF   (hAddrF   ),
    .hRequestM(hRequestM),
    .hAddrM   (hAddrM   ),
    .hWriteM  (hWriteM  ),
    .hSizeM   (hSizeM   ),
    .hWDataM  (hWDataM  ),
    .hReady   (hReady   ),
    .hReadyF  (hReadyF  ),
    .hReadyM  (hReadyM  ),
    .hRequest (hRequest ),
    .hAddr    (hAddr    ),
    .hWrite   (hWrite   ),
    .hSize    (hSize    ),
    .hWData   (hWData   )
  );

  ahbMemory i_ahbMemory (
    .clk     (clk     ),
    .rstN    (rstN    ),
    .hRequest(hRequest),
    .hAddr   (hAddr   ),
    .hWrite  (hWrite  ),
    .hSize   (hSize   ),
    .hWData  (hWData  ),
    .hRData  (hRData  ),
    .hReady  (hReady  )
  );

endmodule

//--- ahbMemory.sv
// Word memory slave with fixed wait states and byte, halfword and word writes
module ahbMemory (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            hRequest,
  input  logic [memSysPkg::dataWidth-1:0] hAddr,
  input  logic                            hWrite,
  input  logic [memSysPkg::hSizeBits-1:0] hSize,
  input  logic [memSysPkg::dataWidth-1:0] hWData,
  output logic [memSysPkg::dataWidth-1:0] hRData,
  output logic                            hReady
);

  logic [memSysPkg::dataWidth-1:0]  mem [memSysPkg::memWords];
  logic [memSysPkg::waitBits-1:0]   waitCnt;
  logic [memSysPkg::memAdrBits-1:0] wIdx;
  logic                             xferDone;

  assign wIdx = hAddr[memSysPkg::memAdrBits+1:2];
  // Wait states used up, ready follows on the next cycle
  assign xferDone = hRequest && !hReady && (waitCnt == memSysPkg::memWaitCycles);

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      waitCnt <= '0;
      hReady  <= 1'b0;
      for (int i = 0; i < memSysPkg::memWords; i++)
        mem[i] <= '0;
    end
    else
    begin
      hReady <= xferDone;
      // Count restarts after every ready
      if (xferDone || hReady || !hRequest)
        waitCnt <= '0;
      else
        waitCnt <= waitCnt + 1'b1;
      if (xferDone && hWrite)
      begin
        case (hSize)
          memSysPkg::hSizeByte: mem[wIdx][8*hAddr[1:0] +: 8] <= hWData[8*hAddr[1:0] +: 8];
          memSysPkg::hSizeHalf: mem[wIdx][16*hAddr[1] +: 16] <= hWData[16*hAddr[1] +: 16];
          default:              mem[wIdx] <= hWData;
        endcase
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (xferDone)
      hRData <= mem[wIdx];
  end

endmodule

//--- busArbiter.sv
// Two-master fixed-priority bus arbiter that keeps the bus for a whole transfer
module busArbiter (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            hRequestF,
  input  logic [memSysPkg::dataWidth-1:0] hAddrF,
  input  logic                            hRequestM,
  input  logic [memSysPkg::dataWidth-1:0] hAddrM,
  input  logic                            hWriteM,
  input  logic [memSysPkg::hSizeBits-1:0] hSizeM,
  input  logic [memSysPkg::dataWidth-1:0] hWDataM,
  input  logic                            hReady,
  output logic                            hReadyF,
  output logic                            hReadyM,
  output logic                            hRequest,
  output logic [memSysPkg::dataWidth-1:0] hAddr,
  output logic                            hWrite,
  output logic [memSysPkg::hSizeBits-1:0] hSize,
  output logic [memSysPkg::dataWidth-1:0] hWData
);

  logic ownF;
  logic ownM;
  logic selF;
  logic selM;

  // Owner keeps the bus while requesting, data master wins otherwise
  always_comb
  begin
    selF = 1'b0;
    selM = 1'b0;
    if (ownM && hRequestM)
      selM = 1'b1;
    else if (ownF && hRequestF)
      selF = 1'b1;
    else if (hRequestM)
      selM = 1'b1;
    else if (hRequestF)
      selF = 1'b1;
  end

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      ownF <= 1'b0;
      ownM <= 1'b0;
    end
    else
    begin
      ownF <= selF;
      ownM <= selM;
    end
  end

  assign hRequest = selF || selM;
  assign hAddr    = selF ? hAddrF : hAddrM;
  // Fetches always go out as word reads
  assign hWrite   = selM && hWriteM;
  assign hSize    = selF ? memSysPkg::hSizeWord : hSizeM;
  assign hWData   = selM ? hWDataM : '0;

  assign hReadyF = hReady && selF;
  assign hReadyM = hReady && selM;

endmodule

//--- dataCache.sv
// Direct-mapped write-through data cache with byte masks and an uncached mode
module dataCache (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic                              enable,
  input  logic                              invalidate,
  input  logic [memSysPkg::dataWidth-1:0]   dataAdrM,
  input  logic [memSysPkg::dataWidth-1:0]   writeDataM,
  input  logic                              memWriteM,
  input  logic                              memtoRegM,
  input  logic [memSysPkg::dataWidth/8-1:0] byteMaskM,
  input  logic                              hReadyM,
  input  logic [memSysPkg::dataWidth-1:0]   hRData,
  output logic [memSysPkg::dataWidth-1:0]   readDataM,
  output logic                              dStall,
  output logic                              hRequestM,
  output logic [memSysPkg::dataWidth-1:0]   hAddrM,
  output logic                              hWriteM,
  output logic [memSysPkg::hSizeBits-1:0]   hSizeM,
  output logic [memSysPkg::dataWidth-1:0]   hWDataM
);

  // Line storage
  logic [memSysPkg::dataWidth-1:0]  lineData [memSysPkg::numDLines][memSysPkg::blockWords];
  logic [memSysPkg::dTagBits-1:0]   lineTag [memSysPkg::numDLines];
  logic [memSysPkg::numDLines-1:0]  lineValid;
  logic [memSysPkg::offsetBits-1:0] fillCnt;

  logic [memSysPkg::dIndexBits-1:0] index;
  logic [memSysPkg::dTagBits-1:0]   tag;
  logic [memSysPkg::offsetBits-1:0] word;
  logic                             hit;
  logic                             readMiss;
  logic                             fillStep;
  logic                             lastReady;
  logic                             done;
  logic [memSysPkg::dataWidth-1:0]  rdBuf;
  logic [memSysPkg::hSizeBits-1:0]  maskSize;
  logic [1:0]                       maskOfs;

  assign index = dataAdrM[memSysPkg::offsetBits+2 +: memSysPkg::dIndexBits];
  assign tag   = dataAdrM[memSysPkg::dataWidth-1 -: memSysPkg::dTagBits];
  assign word  = dataAdrM[2 +: memSysPkg::offsetBits];
  assign hit   = lineValid[index] && (lineTag[index] == tag);

  assign readMiss  = memtoRegM && !memWriteM && !(enable && hit);
  assign fillStep  = enable && !memWriteM && hReadyM;
  // Only the final ready of an access ends it
  assign lastReady = hReadyM && !(fillStep && !(&fillCnt));

  // done covers the one cycle after the closing ready
  assign hRequestM = !done && (memWriteM || readMiss);
  assign dStall    = hRequestM;
  assign readDataM = enable ? lineData[index][word] : rdBuf;

  // Byte mask to transfer size and byte offset
  always_comb
  begin
    maskSize = memSysPkg::hSizeWord;
    maskOfs  = 2'b00;
    case (byteMaskM)
      4'b0011: maskSize = memSysPkg::hSizeHalf;
      4'b1100:
      begin
        maskSize = memSysPkg::hSizeHalf;
        maskOfs  = 2'b10;
      end
      4'b0001: maskSize = memSysPkg::hSizeByte;
      4'b0010:
      begin
        maskSize = memSysPkg::hSizeByte;
        maskOfs  = 2'b01;
      end
      4'b0100:
      begin
        maskSize = memSysPkg::hSizeByte;
        maskOfs  = 2'b10;
      end
      4'b1000:
      begin
        maskSize = memSysPkg::hSizeByte;
        maskOfs  = 2'b11;
      end
      default: maskSize = memSysPkg::hSizeWord;
    endcase
  end

  always_comb
  begin
    if (memWriteM)
      hAddrM = {dataAdrM[memSysPkg::dataWidth-1:2], maskOfs};
    else if (enable)
      hAddrM = {dataAdrM[memSysPkg::dataWidth-1:memSysPkg::offsetBits+2], fillCnt, 2'b00};
    else
      hAddrM = {dataAdrM[memSysPkg::dataWidth-1:2], 2'b00};
  end

  assign hWriteM = memWriteM;
  assign hSizeM  = memWriteM ? maskSize : memSysPkg::hSizeWord;
  assign hWDataM = writeDataM;

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      lineValid <= '0;
      fillCnt   <= '0;
      done      <= 1'b0;
    end
    else
    begin
      if (fillStep)
      begin
        fillCnt <= fillCnt + 1'b1;
        if (&fillCnt)
          lineValid[index] <= 1'b1;
      end
      else if (!enable)
        fillCnt <= '0;
      if (invalidate)
        lineValid <= '0;
      done <= lastReady;
    end
  end

  always_ff @(posedge clk)
  begin
    if (fillStep)
    begin
      lineData[index][fillCnt] <= hRData;
      if (&fillCnt)
        lineTag[index] <= tag;
    end
    // Write hit merges into the line as memory takes the same bytes
    if (enable && memWriteM && hit && hReadyM)
    begin
      for (int b = 0; b < memSysPkg::dataWidth / 8; b++)
      begin
        if (byteMaskM[b])
          lineData[index][word][8*b +: 8] <= writeDataM[8*b +: 8];
      end
    end
    if (!enable && hReadyM)
      rdBuf <= hRData;
  end

endmodule

//--- instrCache.sv
// Direct-mapped read-only instruction cache with an uncached fetch mode
module instrCache (
  input  logic                            clk,
  input  logic                            rstN,
  input  logic                            enable,
  input  logic                            invalidate,
  input  logic [memSysPkg::dataWidth-1:0] pcF,
  input  logic                            hReadyF,
  input  logic [memSysPkg::dataWidth-1:0] hRData,
  output logic [memSysPkg::dataWidth-1:0] instrF,
  output logic                            iStall,
  output logic                            hRequestF,
  output logic [memSysPkg::dataWidth-1:0] hAddrF
);

  // Line storage
  logic [memSysPkg::dataWidth-1:0]  lineData [memSysPkg::numILines][memSysPkg::blockWords];
  logic [memSysPkg::iTagBits-1:0]   lineTag [memSysPkg::numILines];
  logic [memSysPkg::numILines-1:0]  lineValid;
  logic [memSysPkg::offsetBits-1:0] fillCnt;

  // Word held in uncached mode
  logic [memSysPkg::dataWidth-1:0] uncWord;
  logic [memSysPkg::dataWidth-3:0] uncAdr;
  logic                            uncValid;

  logic [memSysPkg::iIndexBits-1:0] index;
  logic [memSysPkg::iTagBits-1:0]   tag;
  logic [memSysPkg::offsetBits-1:0] word;
  logic                             hit;
  logic                             uncHit;

  assign index  = pcF[memSysPkg::offsetBits+2 +: memSysPkg::iIndexBits];
  assign tag    = pcF[memSysPkg::dataWidth-1 -: memSysPkg::iTagBits];
  assign word   = pcF[2 +: memSysPkg::offsetBits];
  assign hit    = lineValid[index] && (lineTag[index] == tag);
  assign uncHit = uncValid && (uncAdr == pcF[memSysPkg::dataWidth-1:2]);

  // Request stays up until the line or word is in place
  assign iStall    = enable ? !hit : !uncHit;
  assign hRequestF = iStall;
  assign instrF    = enable ? lineData[index][word] : uncWord;

  // Fill walks the line one word per ready
  assign hAddrF = enable ? {pcF[memSysPkg::dataWidth-1:memSysPkg::offsetBits+2], fillCnt, 2'b00}
                         : {pcF[memSysPkg::dataWidth-1:2], 2'b00};

  always_ff @(posedge clk or negedge rstN)
  begin
    if (!rstN)
    begin
      lineValid <= '0;
      fillCnt   <= '0;
      uncValid  <= 1'b0;
    end
    else
    begin
      if (enable && hReadyF)
      begin
        fillCnt <= fillCnt + 1'b1;
        // Last word of the line
        if (&fillCnt)
          lineValid[index] <= 1'b1;
      end
      else if (!enable)
        fillCnt <= '0;
      // Invalidate wins over a line completing in the same cycle
      if (invalidate)
        lineValid <= '0;
      if (!enable && hReadyF)
        uncValid <= 1'b1;
      else if (enable || !uncHit)
        uncValid <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (enable && hReadyF)
    begin
      lineData[index][fillCnt] <= hRData;
      if (&fillCnt)
        lineTag[index] <= tag;
    end
    if (!enable && hReadyF)
    begin
      uncWord <= hRData;
      uncAdr  <= pcF[memSysPkg::dataWidth-1:2];
    end
  end

endmodule

//--- memSysPkg.sv
// Sizes, bus transfer-size codes and derived widths for the cache and memory subsystem
package memSysPkg;

  // Bus and word width
  localparam int dataWidth = 32;

  // Cache line geometry
  localparam int blockWords = 4;
  localparam int offsetBits = $clog2(blockWords);

  localparam int numILines = 16;
  localparam int numDLines = 16;
  localparam int iIndexBits = $clog2(numILines);
  localparam int dIndexBits = $clog2(numDLines);

  // Tags hold everything above index, word offset and byte offset
  localparam int iTagBits = dataWidth - iIndexBits - offsetBits - 2;
  localparam int dTagBits = dataWidth - dIndexBits - offsetBits - 2;

  // Word memory, upper address bits ignored
  localparam int memWords   = 1024;
  localparam int memAdrBits = $clog2(memWords);

  // Wait states before each ready pulse
  localparam int memWaitCycles = 2;
  localparam int waitBits      = $clog2(memWaitCycles + 1);

  // Transfer size codes as on the AHB-lite bus
  localparam int hSizeBits = 3;
  localparam logic [hSizeBits-1:0] hSizeByte = 3'd0;
  localparam logic [hSizeBits-1:0] hSizeHalf = 3'd1;
  localparam logic [hSizeBits-1:0] hSizeWord = 3'd2;

endpackage
